// File: src/exec_pkg.sv
// execute unit package: shared word types, opcodes and result classes
package exec_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [2*DATA_W-1:0]   dword_t;    // hi/lo pair or full product
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [4:0]            shamt_t;

    // opcode encodings follow the decode stage
    typedef enum logic [7:0] {
        OP_AND   = 8'b0010_0100,
        OP_OR    = 8'b0010_0101,
        OP_XOR   = 8'b0010_0110,
        OP_NOR   = 8'b0010_0111,
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        OP_MUL   = 8'b1010_1001,
        OP_MULT  = 8'b0001_1000,
        OP_MULTU = 8'b0001_1001,
        OP_MADD  = 8'b1010_0110,
        OP_MADDU = 8'b1010_1000,
        OP_MSUB  = 8'b1010_1010,
        OP_MSUBU = 8'b1010_1011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011
    } exec_op_t;

    typedef enum logic [2:0] {
        LOGIC,
        SHIFT,
        ARITH,
        MUL_LO,
        HILO_READ,
        HILO_ONLY   // no general register write
    } res_class_t;

    function automatic res_class_t op_class(exec_op_t op);
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOR:       return LOGIC;
            OP_SLL, OP_SRL, OP_SRA:              return SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU, OP_CLZ, OP_CLO:     return ARITH;
            OP_MUL:                              return MUL_LO;
            OP_MFHI, OP_MFLO:                    return HILO_READ;
            default:                             return HILO_ONLY;
        endcase
    endfunction

    // two-cycle multiply-accumulate group
    function automatic logic is_acc_op(exec_op_t op);
        return op inside {OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    endfunction

endpackage

// File: src/logic_shift_unit.sv
// logic/shift unit: bitwise ops and barrel shifts of operand b by operand a
`timescale 1ns/1ns

module logic_shift_unit #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  exec_pkg::exec_op_t op_i,
    input  exec_pkg::word_t    a_i,
    input  exec_pkg::word_t    b_i,
    output exec_pkg::word_t    logic_o,
    output exec_pkg::word_t    shift_o
);
    import exec_pkg::*;

    shamt_t shamt;
    word_t  sign_fill;

    assign shamt     = a_i[4:0];
    assign sign_fill = {DATA_W{b_i[DATA_W-1]}};

    always_comb begin
        case (op_i)
            OP_OR: begin
                logic_o = a_i | b_i;
            end
            OP_AND: begin
                logic_o = a_i & b_i;
            end
            OP_XOR: begin
                logic_o = a_i ^ b_i;
            end
            OP_NOR: begin
                logic_o = ~(a_i | b_i);
            end
            default: begin
                logic_o = '0;
            end
        endcase
    end

    always_comb begin
        case (op_i)
            OP_SLL: begin
                shift_o = b_i << shamt;
            end
            OP_SRL: begin
                shift_o = b_i >> shamt;
            end
            OP_SRA: begin
                // fill vacated top bits from the sign, shamt 0 pushes fill out
                shift_o = (sign_fill << (DATA_W - shamt)) | (b_i >> shamt);
            end
            default: begin
                shift_o = '0;
            end
        endcase
    end

endmodule

// File: src/arith_unit.sv
// arithmetic unit: add/sub with overflow, set-less-than, leading zero/one count
`timescale 1ns/1ns

module arith_unit #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  exec_pkg::exec_op_t op_i,
    input  exec_pkg::word_t    a_i,
    input  exec_pkg::word_t    b_i,
    output exec_pkg::word_t    arith_o,
    output logic               overflow_o
);
    import exec_pkg::*;

    localparam int CNT_W = $clog2(DATA_W) + 1;

    logic             sub_op;
    word_t            b_inv;
    word_t            sum;
    logic             lt_signed;
    logic             lt_unsigned;
    word_t            scan;
    logic [CNT_W-1:0] lead_cnt;

    assign sub_op = op_i inside {OP_SUB, OP_SUBU, OP_SLT};

    // a - b as a + ~b + 1
    assign b_inv = sub_op ? ~b_i : b_i;
    assign sum   = a_i + b_inv + word_t'(sub_op);

    // same-sign addends, result flips sign
    assign overflow_o = (a_i[DATA_W-1] == b_inv[DATA_W-1]) &&
                        (sum[DATA_W-1] != a_i[DATA_W-1]);

    // neg < pos, else sign of the difference
    assign lt_signed = (a_i[DATA_W-1] && !b_i[DATA_W-1]) ||
                       ((a_i[DATA_W-1] == b_i[DATA_W-1]) && sum[DATA_W-1]);
    assign lt_unsigned = a_i < b_i;

    // clo counts zeros of the inverted operand
    assign scan = (op_i == OP_CLO) ? ~a_i : a_i;

    always_comb begin
        lead_cnt = CNT_W'(DATA_W);             // no set bit at all
        for (int i = 0; i < DATA_W; i++) begin
            if (scan[i]) begin
                lead_cnt = CNT_W'(DATA_W - 1 - i); // highest set bit wins
            end
        end
    end

    always_comb begin
        case (op_i)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                arith_o = sum;
            end
            OP_SLT: begin
                arith_o = word_t'(lt_signed);
            end
            OP_SLTU: begin
                arith_o = word_t'(lt_unsigned);
            end
            OP_CLZ, OP_CLO: begin
                arith_o = word_t'(lead_cnt);
            end
            default: begin
                arith_o = '0;
            end
        endcase
    end

endmodule

// File: src/mul_acc_unit.sv
// multiply/accumulate unit: signed and unsigned product plus two-cycle MADD/MSUB FSM
`timescale 1ns/1ns

module mul_acc_unit #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_i,
    input  exec_pkg::exec_op_t op_i,
    input  exec_pkg::word_t    a_i,
    input  exec_pkg::word_t    b_i,
    input  exec_pkg::dword_t   hilo_i,
    output exec_pkg::word_t    mul_lo_o,
    output logic               hilo_we_o,
    output exec_pkg::dword_t   hilo_wdata_o,
    output logic               busy_o
);
    import exec_pkg::*;

    typedef enum logic {
        IDLE,
        ACC
    } acc_state_t;

    acc_state_t state;
    dword_t     acc_q;          // captured product, negated for msub

    logic   signed_op;
    logic   neg_prod;
    logic   is_msub;
    logic   acc_start;
    word_t  mag_a;
    word_t  mag_b;
    dword_t mag_prod;
    dword_t prod;

    assign signed_op = op_i inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB};
    assign is_msub   = op_i inside {OP_MSUB, OP_MSUBU};

    // magnitudes for signed ops, raw bits otherwise
    assign mag_a = (signed_op && a_i[DATA_W-1]) ? (~a_i + 1'b1) : a_i;
    assign mag_b = (signed_op && b_i[DATA_W-1]) ? (~b_i + 1'b1) : b_i;

    assign mag_prod = mag_a * mag_b;   // 64-bit context
    assign neg_prod = signed_op && (a_i[DATA_W-1] ^ b_i[DATA_W-1]);
    assign prod     = neg_prod ? (~mag_prod + 1'b1) : mag_prod;

    assign mul_lo_o = prod[DATA_W-1:0];

    assign acc_start = issue_i && is_acc_op(op_i) && (state == IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (acc_start) begin
                        state <= ACC;
                    end
                end
                ACC: begin
                    state <= IDLE;     // second phase is always one cycle
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (acc_start) begin
            acc_q <= is_msub ? (~prod + 1'b1) : prod;
        end
    end

    // mult/multu write straight away, accumulate writes in ACC
    assign hilo_we_o    = (issue_i && (op_i inside {OP_MULT, OP_MULTU})) || (state == ACC);
    assign hilo_wdata_o = (state == ACC) ? (hilo_i + acc_q) : prod;

    assign busy_o = (state == ACC);

endmodule

// File: src/hilo_regs.sv
// hi/lo register block, written by MTHI/MTLO or by the multiplier
`timescale 1ns/1ns

module hilo_regs #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_i,
    input  exec_pkg::exec_op_t op_i,
    input  exec_pkg::word_t    a_i,
    input  logic               mul_we_i,
    input  exec_pkg::dword_t   mul_wdata_i,
    output exec_pkg::dword_t   hilo_o
);
    import exec_pkg::*;

    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (mul_we_i) begin
            hi_q <= mul_wdata_i[2*DATA_W-1:DATA_W];
            lo_q <= mul_wdata_i[DATA_W-1:0];
        end else if (issue_i && op_i == OP_MTHI) begin
            hi_q <= a_i;     // lo untouched
        end else if (issue_i && op_i == OP_MTLO) begin
            lo_q <= a_i;
        end
    end

    assign hilo_o = {hi_q, lo_q};

endmodule

// File: src/exec_unit.sv
// execute unit top: issue decode, result select, overflow suppression, output regs
`timescale 1ns/1ns

module exec_unit #(
    parameter int DATA_W = exec_pkg::DATA_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  exec_pkg::exec_op_t  op_i,
    input  exec_pkg::word_t     a_i,
    input  exec_pkg::word_t     b_i,
    input  exec_pkg::reg_addr_t dest_i,
    input  logic                wr_en_i,
    output logic                busy_o,
    output logic                done_o,
    output logic                wr_en_o,
    output exec_pkg::reg_addr_t dest_o,
    output exec_pkg::word_t     result_o
);
    import exec_pkg::*;

    logic       issue;
    logic       single_issue;
    logic       mul_busy;
    logic       overflow;
    logic       hilo_we;
    logic       wr_allow;
    res_class_t res_class;
    word_t      logic_res;
    word_t      shift_res;
    word_t      arith_res;
    word_t      mul_lo;
    word_t      result_sel;
    dword_t     hilo;
    dword_t     hilo_wdata;

    assign busy_o       = mul_busy;
    assign issue        = valid_i && !mul_busy;       // ignored while busy
    assign single_issue = issue && !is_acc_op(op_i);
    assign res_class    = op_class(op_i);

    logic_shift_unit #(.DATA_W(DATA_W)) u_logic_shift (
        .op_i    (op_i),
        .a_i     (a_i),
        .b_i     (b_i),
        .logic_o (logic_res),
        .shift_o (shift_res)
    );

    arith_unit #(.DATA_W(DATA_W)) u_arith (
        .op_i       (op_i),
        .a_i        (a_i),
        .b_i        (b_i),
        .arith_o    (arith_res),
        .overflow_o (overflow)
    );

    mul_acc_unit #(.DATA_W(DATA_W)) u_mul_acc (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_i      (issue),
        .op_i         (op_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .hilo_i       (hilo),
        .mul_lo_o     (mul_lo),
        .hilo_we_o    (hilo_we),
        .hilo_wdata_o (hilo_wdata),
        .busy_o       (mul_busy)
    );

    hilo_regs #(.DATA_W(DATA_W)) u_hilo (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_i     (issue),
        .op_i        (op_i),
        .a_i         (a_i),
        .mul_we_i    (hilo_we),
        .mul_wdata_i (hilo_wdata),
        .hilo_o      (hilo)
    );

    always_comb begin
        case (res_class)
            LOGIC:     result_sel = logic_res;
            SHIFT:     result_sel = shift_res;
            ARITH:     result_sel = arith_res;
            MUL_LO:    result_sel = mul_lo;
            HILO_READ: result_sel = (op_i == OP_MFHI) ? hilo[2*DATA_W-1:DATA_W]
                                                      : hilo[DATA_W-1:0];
            default:   result_sel = '0;
        endcase
    end

    // signed add/sub overflow drops the write, unsigned forms never do
    assign wr_allow = wr_en_i && (res_class != HILO_ONLY) &&
                      !(overflow && (op_i inside {OP_ADD, OP_SUB}));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_o  <= 1'b0;
            wr_en_o <= 1'b0;
        end else begin
            // busy falls at this edge when an accumulate finishes
            done_o  <= single_issue || mul_busy;
            wr_en_o <= single_issue && wr_allow;
        end
    end

    // payload held through the accumulate second phase
    always_ff @(posedge clk) begin
        if (issue) begin
            dest_o   <= dest_i;
            result_o <= result_sel;
        end
    end

endmodule

// File: bench/exec_checker.sv
// execute unit checker: reference model, shadow hi/lo and comparison at each done_o
`timescale 1ns/1ns

module exec_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  exec_pkg::exec_op_t  op_i,
    input  exec_pkg::word_t     a_i,
    input  exec_pkg::word_t     b_i,
    input  exec_pkg::reg_addr_t dest_i,
    input  logic                wr_en_i,
    input  logic                busy_i,
    input  logic                done_i,
    input  logic                out_wr_en_i,
    input  exec_pkg::reg_addr_t out_dest_i,
    input  exec_pkg::word_t     result_i,
    output int                  err_cnt_o,
    output int                  issue_cnt_o,
    output int                  done_cnt_o
);
    import exec_pkg::*;

    typedef struct packed {
        logic   wr_en;
        logic   has_result;     // hi/lo-only ops leave result_o unchecked
        word_t  result;
        dword_t hilo;
    } ref_t;

    typedef struct packed {
        exec_op_t    op;
        reg_addr_t   dest;
        ref_t        exp;
        logic [31:0] due;       // edge at which done_o should be seen
    } pend_t;

    pend_t  pend_q[$];
    dword_t shadow_hilo;
    logic   busy_exp;
    int     edge_cnt;
    int     err_cnt   = 0;
    int     issue_cnt = 0;
    int     done_cnt  = 0;

    function automatic ref_t ref_model(exec_op_t op, word_t a, word_t b, logic we, dword_t hilo);
        ref_t            r;
        dword_t          sprod;
        dword_t          uprod;
        logic [DATA_W:0] ext;
        int              lead;
        logic            stop;
        r = '{wr_en: we, has_result: 1'b1, result: '0, hilo: hilo};
        sprod = {{DATA_W{a[DATA_W-1]}}, a} * {{DATA_W{b[DATA_W-1]}}, b};
        uprod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
        ext   = (op == OP_SUB) ? {a[DATA_W-1], a} - {b[DATA_W-1], b}
                               : {a[DATA_W-1], a} + {b[DATA_W-1], b};
        lead  = 0;
        stop  = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (stop || a[i] != (op == OP_CLO)) begin
                stop = 1'b1;
            end else begin
                lead++;
            end
        end
        case (op)
            OP_AND:         r.result = a & b;
            OP_OR:          r.result = a | b;
            OP_XOR:         r.result = a ^ b;
            OP_NOR:         r.result = ~(a | b);
            OP_SLL:         r.result = b << a[4:0];
            OP_SRL:         r.result = b >> a[4:0];
            OP_SRA:         r.result = $signed(b) >>> a[4:0];
            OP_ADD, OP_SUB: begin
                r.result = ext[DATA_W-1:0];
                r.wr_en  = we && (ext[DATA_W] == ext[DATA_W-1]);  // must fit in 32 bits
            end
            OP_ADDU:        r.result = a + b;
            OP_SUBU:        r.result = a - b;
            OP_SLT:         r.result = word_t'($signed(a) < $signed(b));
            OP_SLTU:        r.result = word_t'(a < b);
            OP_CLZ, OP_CLO: r.result = word_t'(lead);
            OP_MUL:         r.result = sprod[DATA_W-1:0];
            OP_MFHI:        r.result = hilo[2*DATA_W-1:DATA_W];
            OP_MFLO:        r.result = hilo[DATA_W-1:0];
            OP_MTHI:        r.hilo = {a, hilo[DATA_W-1:0]};
            OP_MTLO:        r.hilo = {hilo[2*DATA_W-1:DATA_W], a};
            OP_MULT:        r.hilo = sprod;
            OP_MULTU:       r.hilo = uprod;
            OP_MADD:        r.hilo = hilo + sprod;
            OP_MADDU:       r.hilo = hilo + uprod;
            OP_MSUB:        r.hilo = hilo - sprod;
            OP_MSUBU:       r.hilo = hilo - uprod;
            default:        r.result = '0;
        endcase
        if (op inside {OP_MTHI, OP_MTLO, OP_MULT, OP_MULTU,
                       OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU}) begin
            r.wr_en      = 1'b0;
            r.has_result = 1'b0;
        end
        return r;
    endfunction

    task automatic check_value(string name, string field, word_t exp, word_t act);
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", name, field, exp, act);
        end
    endtask

    // inputs sampled at the edge hold the values of the cycle just ended
    always @(posedge clk) begin
        pend_t    p;
        ref_t     r;
        exec_op_t op_now;
        if (!rst_n) begin
            pend_q.delete();
            shadow_hilo = '0;
            busy_exp    = 1'b0;
            edge_cnt    = 0;
        end else begin
            edge_cnt++;
            if (busy_i !== busy_exp) begin
                err_cnt++;
                $display("[FAIL] busy_o at edge %0d: expected %b, actual %b",
                         edge_cnt, busy_exp, busy_i);
            end
            if (done_i === 1'b1) begin
                done_cnt++;
                if (pend_q.size() == 0) begin
                    err_cnt++;
                    $display("done_o pulsed with no operation outstanding at edge %0d", edge_cnt);
                end else begin
                    p      = pend_q.pop_front();
                    op_now = p.op;
                    if (p.due != edge_cnt) begin
                        err_cnt++;
                        $display("%s finished at edge %0d instead of edge %0d",
                                 op_now.name(), edge_cnt, p.due);
                    end
                    check_value(op_now.name(), "wr_en", word_t'(p.exp.wr_en), word_t'(out_wr_en_i));
                    check_value(op_now.name(), "dest", word_t'(p.dest), word_t'(out_dest_i));
                    if (p.exp.has_result) begin
                        check_value(op_now.name(), "result", p.exp.result, result_i);
                    end
                end
            end else if (pend_q.size() != 0 && pend_q[0].due <= edge_cnt) begin
                p      = pend_q.pop_front();
                op_now = p.op;
                err_cnt++;
                $display("%s never raised done_o by edge %0d", op_now.name(), edge_cnt);
            end
            busy_exp = 1'b0;
            if (valid_i === 1'b1 && busy_i === 1'b0) begin
                r           = ref_model(op_i, a_i, b_i, wr_en_i, shadow_hilo);
                shadow_hilo = r.hilo;                   // written at the issue edge
                p.op        = op_i;
                p.dest      = dest_i;
                p.exp       = r;
                p.due       = edge_cnt + (is_acc_op(op_i) ? 2 : 1);
                pend_q.push_back(p);
                issue_cnt++;
                busy_exp = is_acc_op(op_i);
            end
        end
    end

    assign err_cnt_o   = err_cnt;
    assign issue_cnt_o = issue_cnt;
    assign done_cnt_o  = done_cnt;

endmodule

// File: bench/tb_exec_unit.sv
// execute unit testbench: clock, reset, directed and random operation streams
`timescale 1ns/1ns

module tb_exec_unit;
    import exec_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int N_RANDOM   = 400;
    localparam int N_DIRECTED = 220;    // upper bound on the directed ops below
    localparam exec_op_t OP_LIST [26] = '{
        OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO,
        OP_MUL, OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
        OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO
    };
    localparam exec_op_t ACC_OPS [4] = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    localparam word_t EDGE_VALS [5] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000,
                                        32'h7FFF_FFFF, 32'h1};

    logic      clk;
    logic      rst_n;
    logic      valid;
    exec_op_t  op;
    word_t     opa;
    word_t     opb;
    reg_addr_t dest;
    logic      wr_en;
    logic      busy;
    logic      done;
    logic      out_wr_en;
    reg_addr_t out_dest;
    word_t     result;
    int        seed = 76;
    int        bench_errors = 0;
    int        chk_errors;
    int        chk_issues;
    int        chk_dones;

    exec_unit #(.DATA_W(DATA_W)) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (valid),
        .op_i     (op),
        .a_i      (opa),
        .b_i      (opb),
        .dest_i   (dest),
        .wr_en_i  (wr_en),
        .busy_o   (busy),
        .done_o   (done),
        .wr_en_o  (out_wr_en),
        .dest_o   (out_dest),
        .result_o (result)
    );

    exec_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid),
        .op_i        (op),
        .a_i         (opa),
        .b_i         (opb),
        .dest_i      (dest),
        .wr_en_i     (wr_en),
        .busy_i      (busy),
        .done_i      (done),
        .out_wr_en_i (out_wr_en),
        .out_dest_i  (out_dest),
        .result_i    (result),
        .err_cnt_o   (chk_errors),
        .issue_cnt_o (chk_issues),
        .done_cnt_o  (chk_dones)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic send_op(exec_op_t o, word_t a, word_t b, logic we);
        @(posedge clk);
        valid <= 1'b1;
        op    <= o;
        opa   <= a;
        opb   <= b;
        dest  <= reg_addr_t'($random(seed));
        wr_en <= we;
    endtask

    task automatic go_idle();
        @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (done !== 1'b1 && cycles < 8);
        if (done !== 1'b1) begin
            bench_errors++;
            $display("accumulate was issued but done_o did not come within %0d cycles", cycles);
        end
    endtask

    // nothing new goes in while the accumulate is busy
    task automatic send_acc(exec_op_t o, word_t a, word_t b, logic we);
        send_op(o, a, b, we);
        go_idle();
        wait_done();
    endtask

    task automatic run_logic_shift();
        exec_op_t lops [4];
        lops = '{OP_AND, OP_OR, OP_XOR, OP_NOR};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 5; j++) begin
                send_op(lops[i], EDGE_VALS[j], word_t'($random(seed)), 1'b1);
            end
            send_op(lops[i], word_t'($random(seed)), word_t'($random(seed)), 1'b1);
        end
        send_op(OP_SRA, 32'd0, 32'h8000_1234, 1'b1);   // shamt from a
        send_op(OP_SRA, 32'd31, 32'h8000_1234, 1'b1);
        send_op(OP_SRA, 32'd4, 32'hF000_0000, 1'b1);
        send_op(OP_SRA, 32'd7, 32'h4000_0000, 1'b1);
        send_op(OP_SLL, 32'd0, 32'hDEAD_BEEF, 1'b1);
        send_op(OP_SLL, 32'd31, 32'hDEAD_BEEF, 1'b1);
        send_op(OP_SRL, 32'd0, 32'h8000_0001, 1'b1);
        send_op(OP_SRL, 32'd31, 32'h8000_0001, 1'b1);
        for (int i = 0; i < 3; i++) begin
            send_op(OP_SLL, word_t'($random(seed)), word_t'($random(seed)), 1'b1);
            send_op(OP_SRL, word_t'($random(seed)), word_t'($random(seed)), 1'b1);
            send_op(OP_SRA, word_t'($random(seed)), word_t'($random(seed)), 1'b1);
        end
        go_idle();
    endtask

    task automatic run_arith();
        exec_op_t aops [6];
        aops = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU};
        send_op(OP_ADD, 32'h7FFF_FFFF, 32'h1, 1'b1);           // overflow drops the write
        send_op(OP_ADD, 32'h8000_0000, 32'hFFFF_FFFF, 1'b1);
        send_op(OP_ADDU, 32'h7FFF_FFFF, 32'h1, 1'b1);
        send_op(OP_SUB, 32'h8000_0000, 32'h1, 1'b1);
        send_op(OP_SUB, 32'h7FFF_FFFF, 32'hFFFF_FFFF, 1'b1);
        send_op(OP_SUBU, 32'h8000_0000, 32'h1, 1'b1);
        send_op(OP_SLT, 32'hFFFF_FFFF, 32'h1, 1'b1);
        send_op(OP_SLTU, 32'hFFFF_FFFF, 32'h1, 1'b1);
        send_op(OP_SLT, 32'h8000_0000, 32'h7FFF_FFFF, 1'b1);
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 4; j++) begin
                send_op(aops[i], word_t'($random(seed)), word_t'($random(seed)), 1'b1);
            end
        end
        go_idle();
    endtask

    task automatic run_count();
        send_op(OP_CLZ, 32'h0, 32'h0, 1'b1);
        send_op(OP_CLZ, 32'hFFFF_FFFF, 32'h0, 1'b1);
        send_op(OP_CLO, 32'h0, 32'h0, 1'b1);
        send_op(OP_CLO, 32'hFFFF_FFFF, 32'h0, 1'b1);
        for (int i = 0; i < 32; i++) begin
            send_op(OP_CLZ, word_t'(1) << i, 32'h0, 1'b1);
            send_op(OP_CLO, ~(word_t'(1) << i), 32'h0, 1'b1);
        end
        go_idle();
    endtask

    // each k gives a different pair of operand signs
    task automatic run_mul();
        word_t ma;
        word_t mb;
        for (int k = 0; k < 4; k++) begin
            ma = {k[0], 31'($random(seed))};
            mb = {k[1], 31'($random(seed))};
            send_op(OP_MUL, ma, mb, 1'b1);
            send_op(OP_MULT, ma, mb, 1'b1);
            send_op(OP_MFHI, 32'h0, 32'h0, 1'b1);
            send_op(OP_MFLO, 32'h0, 32'h0, 1'b1);
            send_op(OP_MULTU, ma, mb, 1'b1);
            send_op(OP_MFHI, 32'h0, 32'h0, 1'b1);
            send_op(OP_MFLO, 32'h0, 32'h0, 1'b1);
        end
        go_idle();
    endtask

    task automatic run_acc();
        word_t ma;
        word_t mb;
        send_op(OP_MTHI, word_t'($random(seed)), 32'h0, 1'b1);
        send_op(OP_MTLO, word_t'($random(seed)), 32'h0, 1'b1);
        for (int k = 0; k < 8; k++) begin
            ma = {k[2], 31'($random(seed))};
            mb = {k[0] ^ k[1], 31'($random(seed))};
            send_acc(ACC_OPS[k % 4], ma, mb, 1'b1);
            send_op(OP_MFHI, 32'h0, 32'h0, 1'b1);
            send_op(OP_MFLO, 32'h0, 32'h0, 1'b1);
        end
        go_idle();
    endtask

    task automatic run_random();
        exec_op_t rop;
        word_t    ra;
        word_t    rb;
        logic     rwe;
        for (int n = 0; n < N_RANDOM; n++) begin
            rop = OP_LIST[{$random(seed)} % 26];
            ra  = word_t'($random(seed));
            rb  = word_t'($random(seed));
            rwe = ($random(seed) & 3) != 0;   // mostly writes
            if (is_acc_op(rop)) begin
                send_acc(rop, ra, rb, rwe);
            end else begin
                send_op(rop, ra, rb, rwe);
            end
        end
        go_idle();
    endtask

    initial begin
        rst_n = 1'b0;
        valid = 1'b0;
        op    = OP_AND;
        opa   = '0;
        opb   = '0;
        dest  = '0;
        wr_en = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        run_logic_shift();
        run_arith();
        run_count();
        run_mul();
        run_acc();
        run_random();
        repeat (4) @(posedge clk);
        @(negedge clk);
        if (chk_issues != chk_dones) begin
            bench_errors++;
            $display("accepted %0d operations but saw %0d done_o pulses", chk_issues, chk_dones);
        end
        $display("errors %0d (checker %0d, bench %0d), issued %0d, completed %0d",
                 chk_errors + bench_errors, chk_errors, bench_errors, chk_issues, chk_dones);
        if (chk_errors + bench_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // at most four cycles per op plus reset and drain
    initial begin
        #(CLK_PERIOD * ((N_DIRECTED + N_RANDOM) * 4 + 100));
        $display("watchdog expired, the run did not finish in its time budget");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: list.f
src/exec_pkg.sv
src/logic_shift_unit.sv
src/arith_unit.sv
src/mul_acc_unit.sv
src/hilo_regs.sv
src/exec_unit.sv
bench/exec_checker.sv
bench/tb_exec_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_unit
RTL_TOP   ?= exec_unit
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
RTL_SRCS  ?= src/exec_pkg.sv src/logic_shift_unit.sv src/arith_unit.sv \
             src/mul_acc_unit.sv src/hilo_regs.sv src/exec_unit.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
